//--- all.f
+incdir+rtl
rtl/lc4_isa_pkg.sv
rtl/lc4_pipe_pkg.sv
rtl/lc4_front_end.sv
rtl/lc4_regfile.sv
rtl/lc4_execute.sv
rtl/lc4_writeback.sv
rtl/lc4_top.sv
verification/lc4_tb.sv

//--- Makefile
SIM  := obj_dir/Vlc4_tb
SRCS := $(filter %.sv,$(shell cat all.f)) rtl/lc4_params.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module lc4_tb -f all.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- verification/lc4_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

// directed tests for the lc4 subset pipeline against an in-order isa model
module lc4_tb;
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   localparam int PROG_TOTAL  = 12 + 12 + 12 + 60;  // dependency, logic, nzp, random
   localparam int NUM_TESTS   = 5;                  // reset counts as one
   localparam int CYCLE_LIMIT = PROG_TOTAL + 10 * NUM_TESTS;

   // one expected retirement with the nzp register as it stood before this insn
   typedef struct packed {
      word_t    pc;
      insn_t    insn;
      logic     rd_we;
      reg_sel_t rd_sel;
      word_t    data;
      logic     nzp_we;
      nzp_t     nzp;
      nzp_t     arch_nzp;
   } retire_t;

   logic       gwe = 1'b0;
   logic       i_reset;
   insn_t      i_imem_insn;
   wire word_t o_imem_addr, o_retire_pc, o_retire_data;
   wire insn_t o_retire_insn;
   wire        o_retire_valid, o_retire_rd_we, o_retire_nzp_we;
   wire reg_sel_t o_retire_rd_sel;
   wire nzp_t  o_retire_nzp, o_nzp;

   insn_t   imem [0:255];            // slot 0 sits at the reset pc
   word_t   fetch_off;
   word_t   mregs [0:7];             // model register file
   nzp_t    m_nzp = '0;              // model nzp register
   retire_t exp_q [$];
   insn_t   prog [$];                // program being assembled by a test
   word_t   next_pc = `LC4_RESET_PC; // first slot not yet handed to the model
   word_t   last_addr;
   logic    addr_track = 1'b0;
   logic    retired_any = 1'b0;
   int      cycles = 0;
   integer  seed = 32'ha9ae;

   always #50 gwe = ~gwe;  // 100 ns period

   // same-cycle instruction memory that returns nop outside the loaded range
   always_comb begin
      fetch_off = o_imem_addr - `LC4_RESET_PC;
      if ($isunknown(o_imem_addr) || fetch_off[15:8] != 8'd0) begin
         i_imem_insn = `LC4_NOP;
      end else begin
         i_imem_insn = imem[fetch_off[7:0]];
      end
   end

   lc4_top u_dut (
      .gwe(gwe), .i_reset(i_reset), .i_imem_insn(i_imem_insn), .o_imem_addr(o_imem_addr),
      .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
      .o_retire_insn(o_retire_insn), .o_retire_rd_we(o_retire_rd_we),
      .o_retire_rd_sel(o_retire_rd_sel), .o_retire_data(o_retire_data),
      .o_retire_nzp_we(o_retire_nzp_we), .o_retire_nzp(o_retire_nzp), .o_nzp(o_nzp)
   );

   // register-register form with the sub-op in [5:3]
   function automatic insn_t rr_insn(logic [3:0] op, int rd, int rs, logic [2:0] sub, int rt);
      return {op, rd[2:0], rs[2:0], sub, rt[2:0]};
   endfunction

   function automatic insn_t imm5_insn(logic [3:0] op, int rd, int rs, int imm);
      return {op, rd[2:0], rs[2:0], 1'b1, imm[4:0]};  // bit 5 picks the immediate
   endfunction

   function automatic insn_t const_insn(int rd, int imm);
      return {`LC4_OP_CONST, rd[2:0], imm[8:0]};
   endfunction

   function automatic nzp_t nzp_of(word_t v);
      if (v == 16'h0000) begin
         return 3'b010;
      end else if (v[15]) begin
         return 3'b100;
      end
      return 3'b001;
   endfunction

   // executes one insn on the model state and queues what W must show
   task automatic model_exec(input insn_t insn, input word_t pc);
      retire_t e;
      word_t   a;
      word_t   b;
      word_t   imm5;
      word_t   res;
      logic    kept;
      a    = mregs[insn[8:6]];
      b    = mregs[insn[2:0]];
      imm5 = {{11{insn[4]}}, insn[4:0]};
      res  = 16'h0000;
      kept = 1'b1;
      case (insn[15:12])
         `LC4_OP_ARITH: begin
            if (insn[5]) res = a + imm5;
            else if (insn[5:3] == `LC4_SUB_ADD) res = a + b;
            else if (insn[5:3] == `LC4_SUB_SUB) res = a - b;
            else kept = 1'b0;  // mul, div
         end
         `LC4_OP_LOGIC: begin
            if (insn[5]) res = a & imm5;
            else if (insn[5:3] == `LC4_SUB_AND) res = a & b;
            else if (insn[5:3] == `LC4_SUB_NOT) res = ~a;
            else if (insn[5:3] == `LC4_SUB_OR) res = a | b;
            else res = a ^ b;
         end
         `LC4_OP_CONST: res = {{7{insn[8]}}, insn[8:0]};
         default: kept = 1'b0;
      endcase
      e.pc       = pc;
      e.insn     = insn;
      e.rd_we    = kept;
      e.rd_sel   = insn[11:9];
      e.data     = res;
      e.nzp_we   = kept;
      e.nzp      = nzp_of(res);
      e.arch_nzp = m_nzp;
      if (kept) begin
         mregs[insn[11:9]] = res;
         m_nzp = e.nzp;
      end
      exp_q.push_back(e);
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s expected %h got %h", $time, name, exp, got);
         $display("TEST FAIL");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // advances one clock and checks pc stepping and any retirement
   task automatic step_cycle();
      retire_t e;
      @(posedge gwe);
      #1;
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, %0d retirements never seen", cycles, exp_q.size());
         $display("TEST FAIL");
         $fatal(1, "cycle limit reached");
      end
      if (addr_track) check_value("o_imem_addr", o_imem_addr, last_addr + 16'd1);
      last_addr = o_imem_addr;
      // once the pipe has filled a retirement is due every cycle
      if (retired_any) check_value("o_retire_valid", 16'(o_retire_valid), 16'd1);
      if (o_retire_valid) begin
         if (exp_q.size() == 0) begin
            $display("retirement of pc %h arrived with nothing left to expect", o_retire_pc);
            $display("TEST FAIL");
            $fatal(1, "unexpected retirement");
         end
         e = exp_q.pop_front();
         check_value("o_retire_pc", o_retire_pc, e.pc);
         retired_any = 1'b1;
         check_value("o_retire_insn", o_retire_insn, e.insn);
         check_value("o_retire_rd_we", 16'(o_retire_rd_we), 16'(e.rd_we));
         check_value("o_retire_nzp_we", 16'(o_retire_nzp_we), 16'(e.nzp_we));
         check_value("o_nzp", 16'(o_nzp), 16'(e.arch_nzp));  // nzp of older insns only
         if (e.rd_we) begin
            check_value("o_retire_rd_sel", 16'(o_retire_rd_sel), 16'(e.rd_sel));
            check_value("o_retire_data", o_retire_data, e.data);
         end
         if (e.nzp_we) check_value("o_retire_nzp", 16'(o_retire_nzp), 16'(e.nzp));
      end
   endtask

   // places prog just ahead of fetch and runs until every slot has retired
   task automatic run_program();
      word_t fetch_pc;
      word_t off;
      fetch_pc = o_imem_addr;  // this slot is already being fetched as a nop
      while (next_pc != fetch_pc + 16'd1) begin
         model_exec(`LC4_NOP, next_pc);
         next_pc = next_pc + 16'd1;
      end
      for (int i = 0; i < prog.size(); i++) begin
         off = next_pc - `LC4_RESET_PC;
         imem[off[7:0]] = prog[i];
         model_exec(prog[i], next_pc);
         next_pc = next_pc + 16'd1;
      end
      prog.delete();
      while (exp_q.size() > 0) step_cycle();
   endtask

   task automatic reset_test();
      $display("reset test");
      repeat (3) begin
         step_cycle();
         check_value("o_retire_valid", 16'(o_retire_valid), 16'd0);
         check_value("o_retire_rd_we", 16'(o_retire_rd_we), 16'd0);
      end
      i_reset = 1'b0;
      check_value("o_imem_addr", o_imem_addr, `LC4_RESET_PC);
      last_addr  = o_imem_addr;
      addr_track = 1'b1;
      repeat (2) step_cycle();  // pc must climb by one
   endtask

   // consumers at distance 1, 2 and 3 hit the M bypass, W bypass and write-through
   task automatic dependency_test();
      $display("dependency test");
      prog.push_back(const_insn(1, 5));
      prog.push_back(imm5_insn(`LC4_OP_ARITH, 2, 1, 3));
      prog.push_back(rr_insn(`LC4_OP_ARITH, 3, 1, `LC4_SUB_ADD, 2));
      prog.push_back(const_insn(5, 100));
      prog.push_back(const_insn(6, 1));
      prog.push_back(rr_insn(`LC4_OP_ARITH, 7, 5, `LC4_SUB_ADD, 3));
      prog.push_back(const_insn(0, -20));
      prog.push_back(const_insn(6, 2));
      prog.push_back(const_insn(4, 3));
      prog.push_back(imm5_insn(`LC4_OP_ARITH, 1, 0, -1));
      prog.push_back(rr_insn(`LC4_OP_ARITH, 2, 1, `LC4_SUB_ADD, 1));
      prog.push_back(rr_insn(`LC4_OP_ARITH, 2, 2, `LC4_SUB_ADD, 2));
      run_program();
   endtask

   task automatic logic_test();
      $display("logic and subtract test");
      prog.push_back(const_insn(1, 90));
      prog.push_back(const_insn(2, -77));
      prog.push_back(const_insn(3, 200));
      prog.push_back(rr_insn(`LC4_OP_ARITH, 4, 1, `LC4_SUB_SUB, 2));
      prog.push_back(rr_insn(`LC4_OP_ARITH, 5, 2, `LC4_SUB_SUB, 3));
      prog.push_back(rr_insn(`LC4_OP_LOGIC, 6, 2, `LC4_SUB_AND, 3));
      prog.push_back(rr_insn(`LC4_OP_LOGIC, 7, 1, `LC4_SUB_OR, 2));
      prog.push_back(rr_insn(`LC4_OP_LOGIC, 0, 2, `LC4_SUB_XOR, 3));
      prog.push_back(rr_insn(`LC4_OP_LOGIC, 4, 2, `LC4_SUB_NOT, 5));  // rt field ignored
      prog.push_back(imm5_insn(`LC4_OP_LOGIC, 5, 2, -3));
      prog.push_back(imm5_insn(`LC4_OP_LOGIC, 6, 1, 12));
      prog.push_back(rr_insn(`LC4_OP_LOGIC, 7, 7, `LC4_SUB_XOR, 7));  // clears to zero
      run_program();
   endtask

   // zero, positive and negative results mixed with insns that must leave nzp alone
   task automatic nzp_test();
      $display("nzp test");
      prog.push_back(const_insn(1, 0));
      prog.push_back(const_insn(2, 37));
      prog.push_back(const_insn(3, -1));
      prog.push_back(`LC4_NOP);
      prog.push_back(rr_insn(`LC4_OP_ARITH, 4, 1, 3'b001, 2));  // mul
      prog.push_back(rr_insn(`LC4_OP_ARITH, 4, 1, `LC4_SUB_SUB, 2));
      prog.push_back(16'hf025);  // trap
      prog.push_back(rr_insn(`LC4_OP_ARITH, 5, 4, `LC4_SUB_ADD, 2));
      prog.push_back(16'h2123);  // cmp
      prog.push_back(16'hd1ff);  // hiconst
      prog.push_back(imm5_insn(`LC4_OP_ARITH, 6, 2, 1));
      prog.push_back(`LC4_NOP);
      run_program();
   endtask

   task automatic random_test();
      int kind;
      int rd;
      int rs;
      int rt;
      int imm;
      $display("random test");
      for (int n = 0; n < 60; n++) begin
         kind = $unsigned($random(seed)) % 9;
         rd   = $random(seed) & 7;
         rs   = $random(seed) & 7;
         rt   = $random(seed) & 7;
         imm  = $random(seed);  // helpers keep the low bits
         case (kind)
            0: prog.push_back(rr_insn(`LC4_OP_ARITH, rd, rs, `LC4_SUB_ADD, rt));
            1: prog.push_back(rr_insn(`LC4_OP_ARITH, rd, rs, `LC4_SUB_SUB, rt));
            2: prog.push_back(imm5_insn(`LC4_OP_ARITH, rd, rs, imm));
            3: prog.push_back(rr_insn(`LC4_OP_LOGIC, rd, rs, `LC4_SUB_AND, rt));
            4: prog.push_back(rr_insn(`LC4_OP_LOGIC, rd, rs, `LC4_SUB_NOT, rt));
            5: prog.push_back(rr_insn(`LC4_OP_LOGIC, rd, rs, `LC4_SUB_OR, rt));
            6: prog.push_back(rr_insn(`LC4_OP_LOGIC, rd, rs, `LC4_SUB_XOR, rt));
            7: prog.push_back(imm5_insn(`LC4_OP_LOGIC, rd, rs, imm));
            default: prog.push_back(const_insn(rd, imm));
         endcase
      end
      run_program();
   endtask

   initial begin
      i_reset = 1'b1;
      imem    = '{default: `LC4_NOP};
      mregs   = '{default: 16'h0000};  // matches the cleared register file
      reset_test();
      dependency_test();
      logic_test();
      nzp_test();
      random_test();
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- rtl/lc4_top.sv
`timescale 1ns/1ps
`default_nettype none

// five-stage lc4 subset core
module lc4_top (
   input  wire                        gwe,
   input  wire                        i_reset,
   input  wire lc4_isa_pkg::insn_t    i_imem_insn,
   output wire lc4_isa_pkg::word_t    o_imem_addr,
   output wire                        o_retire_valid,
   output wire lc4_isa_pkg::word_t    o_retire_pc,
   output wire lc4_isa_pkg::insn_t    o_retire_insn,
   output wire                        o_retire_rd_we,   // W write port doubles as trace
   output wire lc4_isa_pkg::reg_sel_t o_retire_rd_sel,
   output wire lc4_isa_pkg::word_t    o_retire_data,
   output wire                        o_retire_nzp_we,
   output wire lc4_pipe_pkg::nzp_t    o_retire_nzp,
   output wire lc4_pipe_pkg::nzp_t    o_nzp
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   // D stage fields
   wire           d_valid, rs_re, rt_re, d_rd_we, d_nzp_we, use_imm;
   wire word_t    d_pc, imm, rs_data, rt_data;
   wire insn_t    d_insn;
   wire reg_sel_t rs_sel, rt_sel, rd_sel;
   wire alu_op_t  alu_op;
   // X stage fields
   wire           x_valid, x_rd_we, x_nzp_we;
   wire word_t    x_pc, x_result;
   wire insn_t    x_insn;
   wire reg_sel_t x_rd_sel;
   // M bypass source
   wire           m_rd_we;
   wire reg_sel_t m_rd_sel;
   wire word_t    m_result;

   lc4_front_end u_front_end (
      .gwe(gwe), .i_reset(i_reset), .i_imem_insn(i_imem_insn), .o_imem_addr(o_imem_addr),
      .o_d_valid(d_valid), .o_d_pc(d_pc), .o_d_insn(d_insn),
      .o_rs_sel(rs_sel), .o_rt_sel(rt_sel), .o_rd_sel(rd_sel),
      .o_rs_re(rs_re), .o_rt_re(rt_re), .o_rd_we(d_rd_we), .o_nzp_we(d_nzp_we),
      .o_alu_op(alu_op), .o_use_imm(use_imm), .o_imm(imm)
   );

   lc4_regfile u_regfile (
      .gwe(gwe), .i_reset(i_reset), .i_rs_sel(rs_sel), .i_rt_sel(rt_sel),
      .i_rd_sel(o_retire_rd_sel), .i_rd_we(o_retire_rd_we), .i_wdata(o_retire_data),
      .o_rs_data(rs_data), .o_rt_data(rt_data)
   );

   lc4_execute u_execute (
      .gwe(gwe), .i_reset(i_reset), .i_d_valid(d_valid), .i_d_pc(d_pc), .i_d_insn(d_insn),
      .i_rs_sel(rs_sel), .i_rt_sel(rt_sel), .i_rd_sel(rd_sel),
      .i_rs_re(rs_re), .i_rt_re(rt_re), .i_rd_we(d_rd_we), .i_nzp_we(d_nzp_we),
      .i_alu_op(alu_op), .i_use_imm(use_imm), .i_imm(imm),
      .i_rs_data(rs_data), .i_rt_data(rt_data),
      .i_m_rd_sel(m_rd_sel), .i_w_rd_sel(o_retire_rd_sel),
      .i_m_rd_we(m_rd_we), .i_w_rd_we(o_retire_rd_we),
      .i_m_result(m_result), .i_w_result(o_retire_data),
      .o_x_valid(x_valid), .o_x_pc(x_pc), .o_x_insn(x_insn), .o_x_rd_sel(x_rd_sel),
      .o_x_rd_we(x_rd_we), .o_x_nzp_we(x_nzp_we), .o_x_result(x_result)
   );

   lc4_writeback u_writeback (
      .gwe(gwe), .i_reset(i_reset), .i_x_valid(x_valid), .i_x_pc(x_pc), .i_x_insn(x_insn),
      .i_x_rd_sel(x_rd_sel), .i_x_rd_we(x_rd_we), .i_x_nzp_we(x_nzp_we),
      .i_x_result(x_result),
      .o_m_rd_sel(m_rd_sel), .o_m_rd_we(m_rd_we), .o_m_result(m_result),
      .o_w_rd_sel(o_retire_rd_sel), .o_w_rd_we(o_retire_rd_we), .o_w_result(o_retire_data),
      .o_retire_valid(o_retire_valid), .o_retire_pc(o_retire_pc),
      .o_retire_insn(o_retire_insn), .o_retire_nzp_we(o_retire_nzp_we),
      .o_retire_nzp(o_retire_nzp), .o_nzp(o_nzp)
   );

endmodule

`default_nettype wire

//--- rtl/lc4_writeback.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

// M and W stages, nzp register and retirement trace
module lc4_writeback (
   input  wire                        gwe,
   input  wire                        i_reset,
   input  wire                        i_x_valid,
   input  wire lc4_isa_pkg::word_t    i_x_pc,
   input  wire lc4_isa_pkg::insn_t    i_x_insn,
   input  wire lc4_isa_pkg::reg_sel_t i_x_rd_sel,
   input  wire                        i_x_rd_we,
   input  wire                        i_x_nzp_we,
   input  wire lc4_isa_pkg::word_t    i_x_result,
   output lc4_isa_pkg::reg_sel_t      o_m_rd_sel,
   output logic                       o_m_rd_we,
   output lc4_isa_pkg::word_t         o_m_result,
   output lc4_isa_pkg::reg_sel_t      o_w_rd_sel,   // also the regfile write port
   output logic                       o_w_rd_we,
   output lc4_isa_pkg::word_t         o_w_result,
   output logic                       o_retire_valid,
   output lc4_isa_pkg::word_t         o_retire_pc,
   output lc4_isa_pkg::insn_t         o_retire_insn,
   output logic                       o_retire_nzp_we,
   output lc4_pipe_pkg::nzp_t         o_retire_nzp,
   output lc4_pipe_pkg::nzp_t         o_nzp         // architectural nzp
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   logic  m_valid, m_nzp_we;
   word_t m_pc;
   insn_t m_insn;
   nzp_t  nzp_new;
   nzp_t  nzp_q;

   // control for both stages
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         m_valid         <= 1'b0;
         o_m_rd_we       <= 1'b0;
         m_nzp_we        <= 1'b0;
         m_insn          <= `LC4_NOP;
         o_retire_valid  <= 1'b0;
         o_w_rd_we       <= 1'b0;
         o_retire_nzp_we <= 1'b0;
         o_retire_insn   <= `LC4_NOP;
      end else begin
         m_valid         <= i_x_valid;
         o_m_rd_we       <= i_x_rd_we;
         m_nzp_we        <= i_x_nzp_we;
         m_insn          <= i_x_insn;
         o_retire_valid  <= m_valid;
         o_w_rd_we       <= o_m_rd_we;
         o_retire_nzp_we <= m_nzp_we;
         o_retire_insn   <= m_insn;
      end
   end

   always_ff @(posedge gwe) begin
      m_pc        <= i_x_pc;
      o_m_rd_sel  <= i_x_rd_sel;
      o_m_result  <= i_x_result;  // no memory op so M just carries it
      o_retire_pc <= m_pc;
      o_w_rd_sel  <= o_m_rd_sel;
      o_w_result  <= o_m_result;
   end

   assign nzp_new = (o_w_result == '0) ? 3'b010 :   // z
                    !o_w_result[15]    ? 3'b001 :   // p
                                         3'b100;    // n

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         nzp_q <= '0;
      end else if (o_retire_nzp_we) begin
         nzp_q <= nzp_new;
      end
   end

   assign o_retire_nzp = nzp_new;
   assign o_nzp        = nzp_q;

endmodule

`default_nettype wire

//--- rtl/lc4_execute.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

// X stage, D->X registers + bypass + subset alu
module lc4_execute (
   input  wire                        gwe,
   input  wire                        i_reset,
   input  wire                        i_d_valid,
   input  wire lc4_isa_pkg::word_t    i_d_pc,
   input  wire lc4_isa_pkg::insn_t    i_d_insn,
   input  wire lc4_isa_pkg::reg_sel_t i_rs_sel,
   input  wire lc4_isa_pkg::reg_sel_t i_rt_sel,
   input  wire lc4_isa_pkg::reg_sel_t i_rd_sel,
   input  wire                        i_rs_re,
   input  wire                        i_rt_re,
   input  wire                        i_rd_we,
   input  wire                        i_nzp_we,
   input  wire lc4_pipe_pkg::alu_op_t i_alu_op,
   input  wire                        i_use_imm,
   input  wire lc4_isa_pkg::word_t    i_imm,
   input  wire lc4_isa_pkg::word_t    i_rs_data,   // regfile read in D
   input  wire lc4_isa_pkg::word_t    i_rt_data,
   input  wire lc4_isa_pkg::reg_sel_t i_m_rd_sel,
   input  wire lc4_isa_pkg::reg_sel_t i_w_rd_sel,
   input  wire                        i_m_rd_we,
   input  wire                        i_w_rd_we,
   input  wire lc4_isa_pkg::word_t    i_m_result,
   input  wire lc4_isa_pkg::word_t    i_w_result,
   output logic                       o_x_valid,
   output lc4_isa_pkg::word_t         o_x_pc,
   output lc4_isa_pkg::insn_t         o_x_insn,
   output lc4_isa_pkg::reg_sel_t      o_x_rd_sel,
   output logic                       o_x_rd_we,
   output logic                       o_x_nzp_we,
   output lc4_isa_pkg::word_t         o_x_result
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   reg_sel_t x_rs_sel, x_rt_sel;
   logic     x_rs_re, x_rt_re;
   alu_op_t  x_alu_op;
   logic     x_use_imm;
   word_t    x_imm;
   word_t    x_rs_data, x_rt_data;
   word_t    rs_val, rt_val;  // operands after bypass
   word_t    op_b;            // rt or the immediate

   // control half of the X latch
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_x_valid  <= 1'b0;
         o_x_rd_we  <= 1'b0;
         o_x_nzp_we <= 1'b0;
         x_rs_re    <= 1'b0;
         x_rt_re    <= 1'b0;
         o_x_insn   <= `LC4_NOP;
      end else begin
         o_x_valid  <= i_d_valid;
         o_x_rd_we  <= i_rd_we;
         o_x_nzp_we <= i_nzp_we;
         x_rs_re    <= i_rs_re;
         x_rt_re    <= i_rt_re;
         o_x_insn   <= i_d_insn;
      end
   end

   always_ff @(posedge gwe) begin
      o_x_pc     <= i_d_pc;
      o_x_rd_sel <= i_rd_sel;
      x_rs_sel   <= i_rs_sel;
      x_rt_sel   <= i_rt_sel;
      x_alu_op   <= i_alu_op;
      x_use_imm  <= i_use_imm;
      x_imm      <= i_imm;
      x_rs_data  <= i_rs_data;
      x_rt_data  <= i_rt_data;
   end

   // M is younger than W so it wins, regfile data is the fallback
   function automatic word_t bypass(input reg_sel_t sel, input logic re, input word_t rf_data);
      if (re && i_m_rd_we && (i_m_rd_sel == sel)) begin
         return i_m_result;
      end else if (re && i_w_rd_we && (i_w_rd_sel == sel)) begin
         return i_w_result;
      end
      return rf_data;
   endfunction

   always_comb begin
      rs_val = bypass(x_rs_sel, x_rs_re, x_rs_data);
      rt_val = bypass(x_rt_sel, x_rt_re, x_rt_data);
   end

   assign op_b = x_use_imm ? x_imm : rt_val;

   always_comb begin
      case (x_alu_op)
         `LC4_ALU_ADD:   o_x_result = rs_val + op_b;
         `LC4_ALU_SUB:   o_x_result = rs_val - op_b;
         `LC4_ALU_AND:   o_x_result = rs_val & op_b;
         `LC4_ALU_OR:    o_x_result = rs_val | op_b;
         `LC4_ALU_XOR:   o_x_result = rs_val ^ op_b;
         `LC4_ALU_NOT:   o_x_result = ~rs_val;  // rt ignored
         default:        o_x_result = op_b;     // passb for const and nops
      endcase
   end

   // a bubble must never reach the register file
   a_we_valid: assert property (@(posedge gwe) disable iff (i_reset)
      o_x_rd_we |-> o_x_valid);

endmodule

`default_nettype wire

//--- rtl/lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

// eight general registers, two reads and one write
module lc4_regfile (
   input  wire                       gwe,
   input  wire                       i_reset,
   input  wire lc4_isa_pkg::reg_sel_t i_rs_sel,
   input  wire lc4_isa_pkg::reg_sel_t i_rt_sel,
   input  wire lc4_isa_pkg::reg_sel_t i_rd_sel,  // W-stage destination
   input  wire                       i_rd_we,
   input  wire lc4_isa_pkg::word_t   i_wdata,
   output lc4_isa_pkg::word_t        o_rs_data,
   output lc4_isa_pkg::word_t        o_rt_data
);
   import lc4_isa_pkg::*;

   word_t regs [0:7];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   // write-through so D sees what W retires this cycle
   assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

   // an unknown write enable from W would silently corrupt state
   a_we_known: assert property (@(posedge gwe) disable iff (i_reset)
      !$isunknown(i_rd_we));

endmodule

`default_nettype wire

//--- rtl/lc4_front_end.sv
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

// F and D stages, pc + D latch + subset decoder
module lc4_front_end (
   input  wire                     gwe,          // global clock
   input  wire                     i_reset,
   input  wire lc4_isa_pkg::insn_t i_imem_insn,  // same-cycle imem data
   output lc4_isa_pkg::word_t      o_imem_addr,  // F-stage pc
   output logic                    o_d_valid,
   output lc4_isa_pkg::word_t      o_d_pc,
   output lc4_isa_pkg::insn_t      o_d_insn,
   output lc4_isa_pkg::reg_sel_t   o_rs_sel,
   output lc4_isa_pkg::reg_sel_t   o_rt_sel,
   output lc4_isa_pkg::reg_sel_t   o_rd_sel,
   output logic                    o_rs_re,
   output logic                    o_rt_re,
   output logic                    o_rd_we,
   output logic                    o_nzp_we,
   output lc4_pipe_pkg::alu_op_t   o_alu_op,
   output logic                    o_use_imm,    // imm replaces rt in X
   output lc4_isa_pkg::word_t      o_imm
);
   import lc4_isa_pkg::*;
   import lc4_pipe_pkg::*;

   word_t pc_q;       // F-stage pc
   insn_t d_insn_q;
   word_t d_pc_q;
   logic  d_valid_q;
   word_t imm5;       // sign-extended insn[4:0]
   word_t imm9;       // sign-extended insn[8:0]
   logic  kept;       // insn is in the supported subset

   // no branches, so fetch just walks forward
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc_q <= `LC4_RESET_PC;
      end else begin
         pc_q <= pc_q + 16'd1;
      end
   end

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         d_valid_q <= 1'b0;
         d_insn_q  <= `LC4_NOP;  // D holds a bubble out of reset
      end else begin
         d_valid_q <= 1'b1;
         d_insn_q  <= i_imem_insn;
      end
   end

   always_ff @(posedge gwe) begin
      d_pc_q <= pc_q;
   end

   assign imm5 = {{11{d_insn_q[4]}}, d_insn_q[4:0]};
   assign imm9 = {{7{d_insn_q[8]}}, d_insn_q[8:0]};

   // subset decode, anything unknown falls through as a non-writing nop
   always_comb begin
      kept      = 1'b0;
      o_rs_re   = 1'b0;
      o_rt_re   = 1'b0;
      o_use_imm = 1'b0;
      o_imm     = '0;
      o_alu_op  = `LC4_ALU_PASSB;
      case (d_insn_q[15:12])
         `LC4_OP_ARITH: begin
            if (d_insn_q[5]) begin  // add imm5
               kept      = 1'b1;
               o_alu_op  = `LC4_ALU_ADD;
               o_use_imm = 1'b1;
               o_imm     = imm5;
            end else begin
               case (d_insn_q[5:3])
                  `LC4_SUB_ADD: begin
                     kept     = 1'b1;
                     o_alu_op = `LC4_ALU_ADD;
                  end
                  `LC4_SUB_SUB: begin
                     kept     = 1'b1;
                     o_alu_op = `LC4_ALU_SUB;
                  end
                  default: kept = 1'b0;  // mul and div are not supported
               endcase
               o_rt_re = kept;
            end
            o_rs_re = kept;
         end
         `LC4_OP_LOGIC: begin
            kept    = 1'b1;
            o_rs_re = 1'b1;
            if (d_insn_q[5]) begin  // and imm5
               o_alu_op  = `LC4_ALU_AND;
               o_use_imm = 1'b1;
               o_imm     = imm5;
            end else begin
               case (d_insn_q[5:3])
                  `LC4_SUB_AND: o_alu_op = `LC4_ALU_AND;
                  `LC4_SUB_NOT: o_alu_op = `LC4_ALU_NOT;
                  `LC4_SUB_OR:  o_alu_op = `LC4_ALU_OR;
                  `LC4_SUB_XOR: o_alu_op = `LC4_ALU_XOR;
                  default:      kept = 1'b0;
               endcase
               o_rt_re = kept && (d_insn_q[5:3] != `LC4_SUB_NOT);  // not reads rs only
            end
         end
         `LC4_OP_CONST: begin
            kept      = 1'b1;
            o_use_imm = 1'b1;
            o_imm     = imm9;
         end
         default: kept = 1'b0;
      endcase
      o_rd_we  = kept && d_valid_q;
      o_nzp_we = kept && d_valid_q;  // every kept insn sets nzp
   end

   assign o_imem_addr = pc_q;
   assign o_d_valid   = d_valid_q;
   assign o_d_pc      = d_pc_q;
   assign o_d_insn    = d_insn_q;
   assign o_rd_sel    = d_insn_q[11:9];
   assign o_rs_sel    = d_insn_q[8:6];
   assign o_rt_sel    = d_insn_q[2:0];  // kept apart from rs

   // fetch never redirects or holds
   a_pc_step: assert property (@(posedge gwe) disable iff (i_reset)
      !$past(i_reset) |-> (pc_q == $past(pc_q) + 16'd1));

endmodule

`default_nettype wire

//--- rtl/lc4_pipe_pkg.sv
`default_nettype none

// types that only exist inside the pipeline
package lc4_pipe_pkg;

   // decoded alu operation, encodings in lc4_params.svh
   typedef logic [2:0] alu_op_t;

   // condition codes with n in bit 2, z in bit 1, p in bit 0
   typedef logic [2:0] nzp_t;

endpackage

`default_nettype wire

//--- rtl/lc4_isa_pkg.sv
`default_nettype none

// architectural widths of the lc4 isa
package lc4_isa_pkg;

   // data and address share one width
   typedef logic [15:0] word_t;

   // raw instruction word as fetched
   typedef logic [15:0] insn_t;

   // index into the eight-entry register file
   typedef logic [2:0] reg_sel_t;

endpackage

`default_nettype wire

//--- rtl/lc4_params.svh
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// first fetch address out of reset
`define LC4_RESET_PC  16'h8200

// opcode field sits in insn[15:12]
`define LC4_OP_ARITH  4'b0001
`define LC4_OP_LOGIC  4'b0101
`define LC4_OP_CONST  4'b1001

// sub-op field sits in insn[5:3] and insn[5] set means the imm5 form
`define LC4_SUB_ADD   3'b000
`define LC4_SUB_SUB   3'b010
`define LC4_SUB_AND   3'b000
`define LC4_SUB_NOT   3'b001
`define LC4_SUB_OR    3'b010
`define LC4_SUB_XOR   3'b011

// decoded alu operations carried from D to X
`define LC4_ALU_ADD   3'd0
`define LC4_ALU_SUB   3'd1
`define LC4_ALU_AND   3'd2
`define LC4_ALU_OR    3'd3
`define LC4_ALU_XOR   3'd4
`define LC4_ALU_NOT   3'd5
`define LC4_ALU_PASSB 3'd6  // const just forwards the immediate

`define LC4_NOP       16'h0000  // all-zero word is a never-taken branch

`endif
